// File: Makefile
# Verilator flow for the memory stage testbench
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR  ?= verilator
TOP        ?= lsu_tb
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall --timing
VFLAGS     ?= --timing --assert -Wno-fatal
RUN_ARGS   ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# A $fatal in the testbench gives a nonzero exit status
sim: build
	./$(SIM_BIN) $(RUN_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/amo_pkg.sv
// Word-sized atomics only and depends on mem_pkg for XLEN and the opcode width
`default_nettype none

package amo_pkg;

    // A-extension operations, zero means no atomic
    typedef enum logic [mem_pkg::AMO_OPS_W-1:0] {
        AMO_OPS_NONE = 4'd0,
        AMO_OPS_LR   = 4'd1,
        AMO_OPS_SC   = 4'd2,
        AMO_OPS_SWAP = 4'd3,
        AMO_OPS_ADD  = 4'd4,
        AMO_OPS_XOR  = 4'd5,
        AMO_OPS_AND  = 4'd6,
        AMO_OPS_OR   = 4'd7,
        AMO_OPS_MIN  = 4'd8,
        AMO_OPS_MAX  = 4'd9,
        AMO_OPS_MINU = 4'd10,
        AMO_OPS_MAXU = 4'd11
    } type_amo_ops_e;

    typedef struct packed {
        logic [mem_pkg::XLEN-1:0] lsu_addr;
        logic [mem_pkg::XLEN-1:0] rs2_operand;
        logic [mem_pkg::XLEN-1:0] r_data;
    } type_lsu2amo_data_s;

    typedef struct packed {
        type_amo_ops_e amo_ops;
        logic          is_amo;
        // Bus acknowledge seen by the LSU
        logic          ack;
    } type_lsu2amo_ctrl_s;

    typedef struct packed {
        logic [mem_pkg::XLEN-1:0] w_data;
        logic [mem_pkg::XLEN-1:0] amo_wrb_data;
    } type_amo2lsu_data_s;

    typedef struct packed {
        logic ld_req;
        logic st_req;
        logic rd_wr_req;
        logic amo_done;
    } type_amo2lsu_ctrl_s;

endpackage

`default_nettype wire

// File: logic/amo_unit.sv
// One atomic at a time, word-sized only, a single reservation per hart, assumes the bus acks one cycle after a request
`timescale 1ns/1ps
`default_nettype none

module amo_unit (
    input  wire                              clk,
    input  wire                              rst_n_i,

    input  wire amo_pkg::type_lsu2amo_data_s lsu2amo_data_i,
    input  wire amo_pkg::type_lsu2amo_ctrl_s lsu2amo_ctrl_i,

    output amo_pkg::type_amo2lsu_data_s      amo2lsu_data_o,
    output amo_pkg::type_amo2lsu_ctrl_s      amo2lsu_ctrl_o
);

    import mem_pkg::*;
    import amo_pkg::*;

    typedef enum logic [2:0] {
        AMO_IDLE,
        AMO_READ,
        AMO_COMPUTE,
        AMO_WRITE,
        AMO_DONE
    } type_amo_state_e;

    type_amo_state_e state_q;
    type_amo_state_e state_d;
    type_amo_ops_e   amo_ops;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] old_q;
    logic [XLEN-1:0] new_d;
    logic [XLEN-1:0] new_q;
    logic [XLEN-3:0] res_addr_q;
    logic            res_valid_q;
    logic            res_hit;
    logic            ack;
    logic            is_lr;
    logic            is_sc;
    logic            start;
    logic            rd_ack;
    logic            wr_ack;
    logic            amo_done;

    assign amo_ops = lsu2amo_ctrl_i.amo_ops;
    assign addr    = lsu2amo_data_i.lsu_addr;
    assign rs2     = lsu2amo_data_i.rs2_operand;
    assign ack     = lsu2amo_ctrl_i.ack;
    assign is_lr   = (amo_ops == AMO_OPS_LR);
    assign is_sc   = (amo_ops == AMO_OPS_SC);
    assign start   = (state_q == AMO_IDLE) && lsu2amo_ctrl_i.is_amo;
    assign rd_ack  = (state_q == AMO_READ) && ack;
    assign wr_ack  = (state_q == AMO_WRITE) && ack;

    // Reservation match on the word address
    assign res_hit = res_valid_q && (res_addr_q == addr[XLEN-1:2]);

    always_comb begin
        state_d = state_q;
        case (state_q)
            AMO_IDLE: begin
                if (lsu2amo_ctrl_i.is_amo) begin
                    // A failed SC skips the bus
                    if (is_sc) begin
                        state_d = res_hit ? AMO_WRITE : AMO_DONE;
                    end else begin
                        state_d = AMO_READ;
                    end
                end
            end
            AMO_READ:    state_d = ack ? (is_lr ? AMO_IDLE : AMO_COMPUTE) : AMO_READ;
            AMO_COMPUTE: state_d = AMO_WRITE;
            AMO_WRITE:   state_d = ack ? AMO_IDLE : AMO_WRITE;
            AMO_DONE:    state_d = AMO_IDLE;
            default:     state_d = AMO_IDLE;
        endcase
    end

    // RMW ALU on the old word and rs2
    always_comb begin
        case (amo_ops)
            AMO_OPS_SWAP: new_d = rs2;
            AMO_OPS_ADD:  new_d = old_q + rs2;
            AMO_OPS_XOR:  new_d = old_q ^ rs2;
            AMO_OPS_AND:  new_d = old_q & rs2;
            AMO_OPS_OR:   new_d = old_q | rs2;
            AMO_OPS_MIN:  new_d = ($signed(old_q) < $signed(rs2)) ? old_q : rs2;
            AMO_OPS_MAX:  new_d = ($signed(old_q) < $signed(rs2)) ? rs2 : old_q;
            AMO_OPS_MINU: new_d = (old_q < rs2) ? old_q : rs2;
            AMO_OPS_MAXU: new_d = (old_q < rs2) ? rs2 : old_q;
            default:      new_d = old_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= AMO_IDLE;
            res_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (rd_ack && is_lr) begin
                res_valid_q <= 1'b1;
            end else if (start && is_sc) begin
                // SC drops the reservation whatever the outcome
                res_valid_q <= 1'b0;
            end else if (wr_ack && !is_sc && res_hit) begin
                res_valid_q <= 1'b0;
            end
        end
    end

    // Old word, new word and reserved address
    always_ff @(posedge clk) begin
        if (rd_ack) begin
            old_q <= lsu2amo_data_i.r_data;
        end
        if (state_q == AMO_COMPUTE) begin
            new_q <= new_d;
        end
        if (rd_ack && is_lr) begin
            res_addr_q <= addr[XLEN-1:2];
        end
    end

    // LR ends on its read ack, SC and RMW on their write ack
    assign amo_done = (rd_ack && is_lr) || wr_ack || (state_q == AMO_DONE);

    always_comb begin
        amo2lsu_ctrl_o.ld_req    = (start && !is_sc) || (state_q == AMO_READ);
        amo2lsu_ctrl_o.st_req    = (start && is_sc && res_hit) || (state_q == AMO_WRITE);
        amo2lsu_ctrl_o.rd_wr_req = amo_done;
        amo2lsu_ctrl_o.amo_done  = amo_done;
    end

    always_comb begin
        amo2lsu_data_o.w_data = is_sc ? rs2 : new_q;
        if (is_lr) begin
            amo2lsu_data_o.amo_wrb_data = lsu2amo_data_i.r_data;
        end else if (is_sc) begin
            // 1 only for the failed SC, which ends in DONE
            amo2lsu_data_o.amo_wrb_data = {{(XLEN-1){1'b0}}, state_q == AMO_DONE};
        end else begin
            amo2lsu_data_o.amo_wrb_data = old_q;
        end
    end

    // Execute holds the atomic until its one done pulse
    a_done_in_request: assert property (@(posedge clk) disable iff (!rst_n_i)
        amo_done |-> lsu2amo_ctrl_i.is_amo)
        else $error("amo_unit: amo_done without a held atomic request");

endmodule

`default_nettype wire

// File: logic/dmem.sv
// DMEM_DEPTH must be a power of two of at least 2 and a held request is served once, then ignored for one cycle
`timescale 1ns/1ps
`default_nettype none

module dmem #(
    parameter int DMEM_DEPTH = 256
) (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire mem_pkg::type_lsu2dbus_s lsu2dbus_i,
    output mem_pkg::type_dbus2lsu_s      dbus2lsu_o
);

    import mem_pkg::*;

    localparam int IDX_W = $clog2(DMEM_DEPTH);

    type_dbus_word_u  mem_q [DMEM_DEPTH];
    type_dbus_word_u  wdata;
    type_dbus_word_u  rdata_q;
    logic [3:0]       lane_en;
    logic [IDX_W-1:0] idx;
    logic             req;
    logic             serve;
    logic             ack_q;

    assign idx = lsu2dbus_i.addr[IDX_W+1:2];
    assign req = lsu2dbus_i.ld_req || lsu2dbus_i.st_req;
    // Skip the cycle right after an ack so a held request runs once
    assign serve = req && !ack_q;

    // Data replicated on every lane, enables pick the natural ones
    always_comb begin
        case (lsu2dbus_i.st_ops)
            ST_OPS_SB: begin
                wdata.bytes = {4{lsu2dbus_i.w_data[7:0]}};
                lane_en     = 4'b0001 << lsu2dbus_i.addr[1:0];
            end
            ST_OPS_SH: begin
                wdata.halves = {2{lsu2dbus_i.w_data[15:0]}};
                lane_en      = 4'b0011 << {lsu2dbus_i.addr[1], 1'b0};
            end
            ST_OPS_SW: begin
                wdata.word = lsu2dbus_i.w_data;
                lane_en    = 4'b1111;
            end
            default: begin
                wdata.word = lsu2dbus_i.w_data;
                lane_en    = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else begin
            ack_q <= serve;
            if (serve && lsu2dbus_i.st_req) begin
                for (int b = 0; b < 4; b++) begin
                    if (lane_en[b]) begin
                        mem_q[idx].bytes[b] <= wdata.bytes[b];
                    end
                end
            end
        end
    end

    // Read word lines up with ack
    always_ff @(posedge clk) begin
        if (serve && lsu2dbus_i.ld_req) begin
            rdata_q <= mem_q[idx];
        end
    end

    assign dbus2lsu_o.r_data = rdata_q;
    assign dbus2lsu_o.ack    = ack_q;

    // Producer keeps addresses inside the array
    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n_i)
        req |-> (lsu2dbus_i.addr[XLEN-1:2] < DMEM_DEPTH))
        else $error("dmem: address beyond DMEM_DEPTH words");

endmodule

`default_nettype wire

// File: logic/lsu.sv
// Execute must hold its request until lsu_ack_o, no misalignment checks, atomics always go to the bus as whole words
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  wire                              clk,
    input  wire                              rst_n_i,

    input  wire mem_pkg::type_exe2lsu_data_s exe2lsu_data_i,
    input  wire mem_pkg::type_exe2lsu_ctrl_s exe2lsu_ctrl_i,

    input  wire amo_pkg::type_amo2lsu_data_s amo2lsu_data_i,
    input  wire amo_pkg::type_amo2lsu_ctrl_s amo2lsu_ctrl_i,

    input  wire mem_pkg::type_dbus2lsu_s     dbus2lsu_i,

    output amo_pkg::type_lsu2amo_data_s      lsu2amo_data_o,
    output amo_pkg::type_lsu2amo_ctrl_s      lsu2amo_ctrl_o,
    output mem_pkg::type_lsu2dbus_s          lsu2dbus_o,
    output mem_pkg::type_lsu2wrb_data_s      lsu2wrb_data_o,
    output mem_pkg::type_lsu2wrb_ctrl_s      lsu2wrb_ctrl_o,
    output logic                             lsu_ack_o
);

    import mem_pkg::*;
    import amo_pkg::*;

    type_ld_ops_e    ld_ops;
    type_dbus_word_u rdata_u;
    logic [7:0]      rdata_byte;
    logic [15:0]     rdata_hword;
    logic [XLEN-1:0] ld_data;
    logic            is_amo;

    assign ld_ops  = exe2lsu_ctrl_i.ld_ops;
    assign is_amo  = |exe2lsu_ctrl_i.amo_ops;
    assign rdata_u = dbus2lsu_i.r_data;

    // Lane pick from the low address bits
    assign rdata_byte  = rdata_u.bytes[exe2lsu_data_i.alu_result[1:0]];
    assign rdata_hword = rdata_u.halves[exe2lsu_data_i.alu_result[1]];

    // Sign or zero extension to XLEN
    always_comb begin
        case (ld_ops)
            LD_OPS_LB:  ld_data = {{(XLEN-8){rdata_byte[7]}}, rdata_byte};
            LD_OPS_LBU: ld_data = {{(XLEN-8){1'b0}}, rdata_byte};
            LD_OPS_LH:  ld_data = {{(XLEN-16){rdata_hword[15]}}, rdata_hword};
            LD_OPS_LHU: ld_data = {{(XLEN-16){1'b0}}, rdata_hword};
            LD_OPS_LW:  ld_data = rdata_u.word;
            default:    ld_data = '0;
        endcase
    end

    // Bus drive, the AMO unit owns requests and write data during atomics
    always_comb begin
        lsu2dbus_o.addr = exe2lsu_data_i.alu_result;
        if (is_amo) begin
            lsu2dbus_o.ld_req        = amo2lsu_ctrl_i.ld_req;
            lsu2dbus_o.st_req        = amo2lsu_ctrl_i.st_req;
            lsu2dbus_o.w_data        = amo2lsu_data_i.w_data;
            // AMO writes are always whole words
            lsu2dbus_o.st_ops        = ST_OPS_SW;
            lsu2wrb_ctrl_o.rd_wr_req = amo2lsu_ctrl_i.rd_wr_req;
        end else begin
            lsu2dbus_o.ld_req        = |ld_ops;
            lsu2dbus_o.st_req        = |exe2lsu_ctrl_i.st_ops;
            lsu2dbus_o.w_data        = exe2lsu_data_i.rs2_data;
            lsu2dbus_o.st_ops        = exe2lsu_ctrl_i.st_ops;
            lsu2wrb_ctrl_o.rd_wr_req = exe2lsu_ctrl_i.rd_wr_req;
        end
        lsu2wrb_ctrl_o.rd_wrb_sel = exe2lsu_ctrl_i.rd_wrb_sel;
    end

    // Request side of the AMO unit
    always_comb begin
        lsu2amo_data_o.lsu_addr    = exe2lsu_data_i.alu_result;
        lsu2amo_data_o.rs2_operand = exe2lsu_data_i.rs2_data;
        lsu2amo_data_o.r_data      = rdata_u.word;
    end

    always_comb begin
        lsu2amo_ctrl_o.amo_ops = type_amo_ops_e'(exe2lsu_ctrl_i.amo_ops);
        lsu2amo_ctrl_o.is_amo  = is_amo;
        lsu2amo_ctrl_o.ack     = dbus2lsu_i.ack;
    end

    // Writeback payload
    always_comb begin
        lsu2wrb_data_o.alu_result = exe2lsu_data_i.alu_result;
        lsu2wrb_data_o.pc_next    = exe2lsu_data_i.pc_next;
        lsu2wrb_data_o.rd_addr    = exe2lsu_ctrl_i.rd_addr;
        // AMO result wins on completion
        if (amo2lsu_ctrl_i.amo_done) begin
            lsu2wrb_data_o.r_data = amo2lsu_data_i.amo_wrb_data;
        end else begin
            lsu2wrb_data_o.r_data = ld_data;
        end
    end

    // Atomics finish on amo_done, plain accesses on the bus ack
    assign lsu_ack_o = is_amo ? amo2lsu_ctrl_i.amo_done : dbus2lsu_i.ack;

    // Execute decodes one access kind per plain request
    a_ld_st_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !is_amo |-> !(lsu2dbus_o.ld_req && lsu2dbus_o.st_req))
        else $error("lsu: load and store requested together");

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
// Memory stage without MMU, CSR or forwarding and with one memory operation in flight at a time
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int DMEM_DEPTH = 256
) (
    input  wire                              clk,
    input  wire                              rst_n_i,
    input  wire mem_pkg::type_exe2lsu_data_s exe2lsu_data_i,
    input  wire mem_pkg::type_exe2lsu_ctrl_s exe2lsu_ctrl_i,
    output mem_pkg::type_lsu2wrb_data_s      lsu2wrb_data_o,
    output mem_pkg::type_lsu2wrb_ctrl_s      lsu2wrb_ctrl_o,
    output logic                             lsu_ack_o
);

    import mem_pkg::*;
    import amo_pkg::*;

    // LSU and AMO unit handshake
    type_lsu2amo_data_s lsu2amo_data;
    type_lsu2amo_ctrl_s lsu2amo_ctrl;
    type_amo2lsu_data_s amo2lsu_data;
    type_amo2lsu_ctrl_s amo2lsu_ctrl;

    // Data bus
    type_lsu2dbus_s     lsu2dbus;
    type_dbus2lsu_s     dbus2lsu;

    lsu u_lsu (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .exe2lsu_data_i (exe2lsu_data_i),
        .exe2lsu_ctrl_i (exe2lsu_ctrl_i),
        .amo2lsu_data_i (amo2lsu_data),
        .amo2lsu_ctrl_i (amo2lsu_ctrl),
        .dbus2lsu_i     (dbus2lsu),
        .lsu2amo_data_o (lsu2amo_data),
        .lsu2amo_ctrl_o (lsu2amo_ctrl),
        .lsu2dbus_o     (lsu2dbus),
        .lsu2wrb_data_o (lsu2wrb_data_o),
        .lsu2wrb_ctrl_o (lsu2wrb_ctrl_o),
        .lsu_ack_o      (lsu_ack_o)
    );

    amo_unit u_amo_unit (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .lsu2amo_data_i (lsu2amo_data),
        .lsu2amo_ctrl_i (lsu2amo_ctrl),
        .amo2lsu_data_o (amo2lsu_data),
        .amo2lsu_ctrl_o (amo2lsu_ctrl)
    );

    dmem #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_dmem (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .lsu2dbus_i (lsu2dbus),
        .dbus2lsu_o (dbus2lsu)
    );

endmodule

`default_nettype wire

// File: logic/mem_pkg.sv
// Little-endian 32-bit data bus with byte lanes; amo_pkg reads the AMO opcode width here and must compile after this package
`default_nettype none

package mem_pkg;

    // Data path width
    localparam int XLEN = 32;
    // Raw AMO opcode field in the execute request, decoded by amo_pkg
    localparam int AMO_OPS_W = 4;

    // Load kinds from execute
    typedef enum logic [2:0] {
        LD_OPS_NONE = 3'd0,
        LD_OPS_LB   = 3'd1,
        LD_OPS_LBU  = 3'd2,
        LD_OPS_LH   = 3'd3,
        LD_OPS_LHU  = 3'd4,
        LD_OPS_LW   = 3'd5
    } type_ld_ops_e;

    // Store kinds from execute, also carried on the bus
    typedef enum logic [1:0] {
        ST_OPS_NONE = 2'd0,
        ST_OPS_SB   = 2'd1,
        ST_OPS_SH   = 2'd2,
        ST_OPS_SW   = 2'd3
    } type_st_ops_e;

    // One bus word, seen whole or split into byte and halfword lanes
    typedef union packed {
        logic [XLEN-1:0]  word;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } type_dbus_word_u;

    typedef struct packed {
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] pc_next;
    } type_exe2lsu_data_s;

    typedef struct packed {
        type_ld_ops_e         ld_ops;
        type_st_ops_e         st_ops;
        logic [AMO_OPS_W-1:0] amo_ops;
        logic [4:0]           rd_addr;
        logic                 rd_wr_req;
        logic [1:0]           rd_wrb_sel;
    } type_exe2lsu_ctrl_s;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] w_data;
        logic            ld_req;
        logic            st_req;
        type_st_ops_e    st_ops;
    } type_lsu2dbus_s;

    typedef struct packed {
        type_dbus_word_u r_data;
        logic            ack;
    } type_dbus2lsu_s;

    typedef struct packed {
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] r_data;
        logic [XLEN-1:0] pc_next;
        logic [4:0]      rd_addr;
    } type_lsu2wrb_data_s;

    typedef struct packed {
        logic       rd_wr_req;
        logic [1:0] rd_wrb_sel;
    } type_lsu2wrb_ctrl_s;

endpackage

`default_nettype wire

// File: src.f
logic/mem_pkg.sv
logic/amo_pkg.sv
logic/lsu.sv
logic/amo_unit.sv
logic/dmem.sv
logic/lsu_top.sv
tb/lsu_tb.sv

// File: tb/lsu_tb.sv
// Needs a simulator with timing support, runs DMEM_DEPTH at 64 and keeps every access inside words 0 to 7
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    import mem_pkg::*;
    import amo_pkg::*;

    localparam int DMEM_DEPTH = 64;
    localparam int CLK_HALF   = 4;
    localparam int DRIVE_DLY  = 1;
    // Directed sections hold 14 + 13 + 27 + 12 requests
    localparam int N_DIRECTED      = 66;
    localparam int N_RANDOM        = 300;
    localparam int N_TESTS         = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_CYCLES = N_TESTS * 8 + 100;

    logic               clk;
    logic               rst_n;
    type_exe2lsu_data_s exe_data;
    type_exe2lsu_ctrl_s exe_ctrl;
    type_lsu2wrb_data_s wrb_data;
    type_lsu2wrb_ctrl_s wrb_ctrl;
    logic               lsu_ack;

    // Reference memory and LR reservation
    logic [XLEN-1:0] ref_mem [DMEM_DEPTH] = '{default: '0};
    logic            rsv_valid = 1'b0;
    int unsigned     rsv_idx   = 0;

    logic [31:0] lfsr_q    = 32'd66742;
    string       test_name = "reset";
    int          issued    = 0;
    int          acked     = 0;

    lsu_top #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) uut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .exe2lsu_data_i (exe_data),
        .exe2lsu_ctrl_i (exe_ctrl),
        .lsu2wrb_data_o (wrb_data),
        .lsu2wrb_ctrl_o (wrb_ctrl),
        .lsu_ack_o      (lsu_ack)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [XLEN-1:0] addr_of(input int widx, input int off);
        return XLEN'(widx * 4 + off);
    endfunction

    // New memory word of a read-modify-write AMO
    function automatic logic [XLEN-1:0] amo_result(input type_amo_ops_e op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        case (op)
            AMO_OPS_SWAP: return b;
            AMO_OPS_ADD:  return a + b;
            AMO_OPS_XOR:  return a ^ b;
            AMO_OPS_AND:  return a & b;
            AMO_OPS_OR:   return a | b;
            AMO_OPS_MIN:  return ($signed(a) <= $signed(b)) ? a : b;
            AMO_OPS_MAX:  return ($signed(a) >= $signed(b)) ? a : b;
            AMO_OPS_MINU: return (a <= b) ? a : b;
            AMO_OPS_MAXU: return (a >= b) ? a : b;
            default:      return a;
        endcase
    endfunction

    // Atomics on the model, returns what rd receives
    function automatic logic [XLEN-1:0] ref_amo(input type_amo_ops_e op, input int unsigned idx,
                                                input logic [XLEN-1:0] rs2);
        logic [XLEN-1:0] cur;
        logic [XLEN-1:0] res;
        logic            hit;
        cur = ref_mem[idx];
        hit = rsv_valid && (rsv_idx == idx);
        res = cur;
        case (op)
            AMO_OPS_LR: begin
                rsv_valid = 1'b1;
                rsv_idx   = idx;
            end
            AMO_OPS_SC: begin
                if (hit) begin
                    ref_mem[idx] = rs2;
                    res          = '0;
                end else begin
                    res = 32'd1;
                end
                // Any SC drops the reservation
                rsv_valid = 1'b0;
            end
            default: begin
                ref_mem[idx] = amo_result(op, cur, rs2);
                if (hit) begin
                    rsv_valid = 1'b0;
                end
            end
        endcase
        return res;
    endfunction

    // Expected writeback data of one request, model updated as it retires
    function automatic logic [XLEN-1:0] ref_access(input type_exe2lsu_data_s d,
                                                   input type_exe2lsu_ctrl_s c);
        int unsigned     idx;
        int unsigned     sh;
        logic [XLEN-1:0] cur;
        logic [XLEN-1:0] lane;
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] res;
        idx = int'(d.alu_result >> 2);
        sh  = 8 * int'(d.alu_result[1:0]);
        cur = ref_mem[idx];
        res = '0;
        if (c.amo_ops != '0) begin
            res = ref_amo(type_amo_ops_e'(c.amo_ops), idx, d.rs2_data);
        end else if (c.st_ops != ST_OPS_NONE) begin
            case (c.st_ops)
                ST_OPS_SB: mask = 32'h0000_00ff << sh;
                ST_OPS_SH: mask = 32'h0000_ffff << sh;
                default:   mask = '1;
            endcase
            // Store data sits on its natural lanes
            ref_mem[idx] = (cur & ~mask) | ((d.rs2_data << sh) & mask);
        end else begin
            lane = cur >> sh;
            case (c.ld_ops)
                LD_OPS_LB:  res = {{24{lane[7]}}, lane[7:0]};
                LD_OPS_LBU: res = {24'h0, lane[7:0]};
                LD_OPS_LH:  res = {{16{lane[15]}}, lane[15:0]};
                LD_OPS_LHU: res = {16'h0, lane[15:0]};
                default:    res = cur;
            endcase
        end
        return res;
    endfunction

    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rdata(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s r_data expected %h actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    // Pass-through fields only, r_data has its own check
    task automatic check_wrb_data(input string name, input type_lsu2wrb_data_s exp,
                                  input type_lsu2wrb_data_s act);
        if (exp.alu_result !== act.alu_result || exp.pc_next !== act.pc_next ||
            exp.rd_addr !== act.rd_addr) begin
            $display("CHECK FAILED %s wrb_data expected a=%h p=%h rd=%0d actual a=%h p=%h rd=%0d",
                     name, exp.alu_result, exp.pc_next, exp.rd_addr,
                     act.alu_result, act.pc_next, act.rd_addr);
            stop_with_failure();
        end
    endtask

    task automatic check_wrb_ctrl(input string name, input type_lsu2wrb_ctrl_s exp,
                                  input type_lsu2wrb_ctrl_s act);
        if (exp !== act) begin
            $display("CHECK FAILED %s wrb_ctrl expected wr=%b sel=%0d actual wr=%b sel=%0d",
                     name, exp.rd_wr_req, exp.rd_wrb_sel, act.rd_wr_req, act.rd_wrb_sel);
            stop_with_failure();
        end
    endtask

    // Present one request and hold it until the acknowledge
    task automatic issue(input string name, input type_ld_ops_e ld, input type_st_ops_e st,
                         input type_amo_ops_e amo, input logic [XLEN-1:0] addr,
                         input logic [XLEN-1:0] rs2);
        test_name           = name;
        exe_data.alu_result = addr;
        exe_data.rs2_data   = rs2;
        exe_data.pc_next    = addr + 32'd4;
        exe_ctrl.ld_ops     = ld;
        exe_ctrl.st_ops     = st;
        exe_ctrl.amo_ops    = amo;
        exe_ctrl.rd_addr    = 5'(take_bits(5));
        exe_ctrl.rd_wr_req  = take_bits(1) != 0;
        exe_ctrl.rd_wrb_sel = 2'(take_bits(2));
        issued++;
        do begin
            @(negedge clk);
        end while (!lsu_ack);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic idle_cycles(input int n);
        exe_data = '0;
        exe_ctrl = '0;
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // Compare at mid-cycle while the acknowledge is stable
    always @(negedge clk) begin : compare_on_ack
        logic [XLEN-1:0]    exp_rdata;
        type_lsu2wrb_data_s exp_data;
        type_lsu2wrb_ctrl_s exp_ctrl;
        if (rst_n && lsu_ack) begin
            if (exe_ctrl.ld_ops == LD_OPS_NONE && exe_ctrl.st_ops == ST_OPS_NONE &&
                exe_ctrl.amo_ops == '0) begin
                $display("Acknowledge seen while no request was presented");
                stop_with_failure();
            end else begin
                exp_ctrl.rd_wrb_sel = exe_ctrl.rd_wrb_sel;
                // Atomics always write rd on completion
                exp_ctrl.rd_wr_req  = (exe_ctrl.amo_ops != '0) ? 1'b1 : exe_ctrl.rd_wr_req;
                exp_rdata = ref_access(exe_data, exe_ctrl);
                exp_data.alu_result = exe_data.alu_result;
                exp_data.r_data     = exp_rdata;
                exp_data.pc_next    = exe_data.pc_next;
                exp_data.rd_addr    = exe_ctrl.rd_addr;
                check_wrb_ctrl(test_name, exp_ctrl, wrb_ctrl);
                check_wrb_data(test_name, exp_data, wrb_data);
                // Plain stores carry no rd data
                if (exe_ctrl.st_ops == ST_OPS_NONE) begin
                    check_rdata(test_name, exp_rdata, wrb_data.r_data);
                end
                acked++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout with no acknowledge after %0d cycles", WATCHDOG_CYCLES);
        stop_with_failure();
    end

    initial begin : stimulus
        type_ld_ops_e    ld;
        type_st_ops_e    st;
        type_amo_ops_e   amo;
        logic [XLEN-1:0] old_word;
        logic [XLEN-1:0] operand;
        int              step;
        int              kind;
        int              widx;
        int              off;
        rst_n    = 1'b0;
        exe_data = '0;
        exe_ctrl = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        idle_cycles(1);

        // Stores of every size and lane, each read back as a word
        for (int s = 1; s <= 3; s++) begin
            st   = type_st_ops_e'(s);
            step = (st == ST_OPS_SB) ? 1 : (st == ST_OPS_SH) ? 2 : 4;
            for (int o = 0; o < 4; o += step) begin
                issue($sformatf("%s off %0d", st.name(), o), LD_OPS_NONE, st, AMO_OPS_NONE,
                      addr_of(1, o), take_bits(32));
                issue("word readback", LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, addr_of(1, 0), '0);
            end
        end

        // Byte and halfword loads with both signs in the lanes
        issue("load pattern", LD_OPS_NONE, ST_OPS_SW, AMO_OPS_NONE, addr_of(2, 0), 32'h7F80_C301);
        for (int l = 1; l <= 4; l++) begin
            ld   = type_ld_ops_e'(l);
            step = (ld == LD_OPS_LB || ld == LD_OPS_LBU) ? 1 : 2;
            for (int o = 0; o < 4; o += step) begin
                issue($sformatf("%s off %0d", ld.name(), o), ld, ST_OPS_NONE, AMO_OPS_NONE,
                      addr_of(2, o), '0);
            end
        end

        // Old word negative, operand positive
        for (int a = 3; a <= 11; a++) begin
            amo      = type_amo_ops_e'(a);
            old_word = take_bits(32) | 32'h8000_0000;
            operand  = take_bits(32) & 32'h7FFF_FFFF;
            issue("amo old word", LD_OPS_NONE, ST_OPS_SW, AMO_OPS_NONE, addr_of(3, 0), old_word);
            issue(amo.name(), LD_OPS_NONE, ST_OPS_NONE, amo, addr_of(3, 0), operand);
            issue("amo new word", LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, addr_of(3, 0), '0);
        end

        // LR and SC pairs
        issue("lr", LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_LR, addr_of(4, 0), '0);
        issue("sc ok", LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_SC, addr_of(4, 0), take_bits(32));
        issue("sc ok word", LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, addr_of(4, 0), '0);
        issue("sc no rsv", LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_SC, addr_of(4, 0), take_bits(32));
        issue("sc no rsv word", LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, addr_of(4, 0), '0);
        issue("lr", LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_LR, addr_of(4, 0), '0);
        issue("sc other word", LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_SC, addr_of(5, 0), take_bits(32));
        issue("sc other readback", LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, addr_of(5, 0), '0);
        issue("lr", LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_LR, addr_of(4, 0), '0);
        issue("amo on rsv", LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_ADD, addr_of(4, 0), take_bits(32));
        issue("sc after amo", LD_OPS_NONE, ST_OPS_NONE, AMO_OPS_SC, addr_of(4, 0), take_bits(32));
        issue("sc after amo word", LD_OPS_LW, ST_OPS_NONE, AMO_OPS_NONE, addr_of(4, 0), '0);
        idle_cycles(2);

        // Mixed traffic with occasional idle gaps
        for (int n = 0; n < N_RANDOM; n++) begin
            kind = int'(take_bits(5)) % 19;
            widx = int'(take_bits(3));
            ld   = LD_OPS_NONE;
            st   = ST_OPS_NONE;
            amo  = AMO_OPS_NONE;
            step = 4;
            if (kind < 5) begin
                ld   = type_ld_ops_e'(kind + 1);
                step = (kind < 2) ? 1 : (kind < 4) ? 2 : 4;
            end else if (kind < 8) begin
                st   = type_st_ops_e'(kind - 4);
                step = (kind == 5) ? 1 : (kind == 6) ? 2 : 4;
            end else begin
                amo = type_amo_ops_e'(kind - 7);
            end
            off = (step == 1) ? int'(take_bits(2)) : (step == 2) ? 2 * int'(take_bits(1)) : 0;
            issue("random mix", ld, st, amo, addr_of(widx, off), take_bits(32));
            if (take_bits(1) != 0) begin
                idle_cycles(1);
            end
        end

        idle_cycles(4);
        if (acked != issued) begin
            $display("Saw %0d acknowledges for %0d issued requests", acked, issued);
            stop_with_failure();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire
